// File: verification/stream_cases.txt
# columns: case name, command (write, wait, read, check), argument
# write and read take a count, check takes the expected fill count, wait takes 0
even write 8
even wait 0
even check 8
even read 3
odd write 3
odd wait 0
odd check 5
odd read 2
odd wait 0
odd check 1
odd write 1
odd wait 0
odd read 1
empty read 2
empty wait 0
empty check 0
flood write 61
flood wait 0
flood check 41
flood read 21
flood wait 0
flood check 1

// File: sim.f
verilog/stream_buffer_pkg.sv
verilog/word_packer.sv
verilog/bulk_store.sv
verilog/out_queue.sv
verilog/fill_monitor.sv
verilog/stream_buffer.sv
verification/tb_clock.sv
verification/stream_buffer_scoreboard.sv
verification/stream_buffer_checker.sv
verification/stream_buffer_tb.sv

// File: Bender.yml
package:
  name: stream_buffer

sources:
  - files:
      - verilog/stream_buffer_pkg.sv
      - verilog/word_packer.sv
      - verilog/bulk_store.sv
      - verilog/out_queue.sv
      - verilog/fill_monitor.sv
      - verilog/stream_buffer.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/stream_buffer_scoreboard.sv
      - verification/stream_buffer_checker.sv
      - verification/stream_buffer_tb.sv

// File: verification/stream_buffer_tb.sv
`default_nettype none

module stream_buffer_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int STORE_ADDR_W = 4;
	localparam int QUEUE_DEPTH  = 4;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = (1 << STORE_ADDR_W) + QUEUE_DEPTH + 4;
	localparam int MAX_CASES    = 64;

	logic                                 ti_clk;
	logic                                 rst_n;
	logic                                 write;
	stream_buffer_pkg::sample_t           data_in;
	logic                                 read;
	logic [stream_buffer_pkg::WORD_W-1:0] data_out;
	stream_buffer_pkg::fill_t             fill_count;
	logic                                 check_req;
	stream_buffer_pkg::fill_t             exp_fill;
	logic [8*16-1:0]                      case_name;
	int                                   mismatches;
	int                                   model_errors;
	int                                   setup_errors;
	int                                   budget;
	integer                               seed;
	int                                   n_cases;
	logic [8*16-1:0]                      names [MAX_CASES];
	logic [8*16-1:0]                      cmds [MAX_CASES];
	int                                   args [MAX_CASES];

	tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.ti_clk(ti_clk), .rst_n(rst_n)
	);

	stream_buffer #(.STORE_ADDR_W(STORE_ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) uut (
		.ti_clk(ti_clk), .rst_n(rst_n), .write(write), .data_in(data_in),
		.read(read), .data_out(data_out), .fill_count(fill_count)
	);

	stream_buffer_scoreboard #(
		.STORE_ADDR_W(STORE_ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)
	) u_scoreboard (
		.ti_clk(ti_clk), .rst_n(rst_n), .write(write), .data_in(data_in),
		.read(read), .data_out(data_out), .fill_count(fill_count),
		.check_req(check_req), .exp_fill(exp_fill), .case_name(case_name),
		.mismatches(mismatches), .model_errors(model_errors)
	);

	// reads one command per line and adds each run length to the watchdog budget
	task automatic load_cases();
		int              fd;
		int              fields;
		logic [8*80-1:0] line;
		logic [8*16-1:0] name_f;
		logic [8*16-1:0] cmd_f;
		int              arg_f;
		fd = $fopen("verification/stream_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file verification/stream_cases.txt");
			setup_errors++;
		end else begin
			while (!$feof(fd) && n_cases < MAX_CASES) begin
				line   = '0;
				fields = $fgets(line, fd);
				fields = $sscanf(line, "%s %s %d", name_f, cmd_f, arg_f);
				// comment lines open with a hash
				if (fields == 3 && name_f != "#") begin
					names[n_cases] = name_f;
					cmds[n_cases]  = cmd_f;
					args[n_cases]  = arg_f;
					if (cmd_f == "wait") begin
						budget += IDLE_CYCLES;
					end else begin
						budget += (cmd_f == "check") ? 1 : arg_f;
					end
					n_cases++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_case(input int idx);
		int n;
		case_name = names[idx];
		if (cmds[idx] == "write") begin
			for (n = 0; n < args[idx]; n++) begin
				write   = 1'b1;
				data_in = stream_buffer_pkg::sample_t'($random(seed));
				@(negedge ti_clk);
			end
			write = 1'b0;
		end else if (cmds[idx] == "read") begin
			for (n = 0; n < args[idx]; n++) begin
				read = 1'b1;
				@(negedge ti_clk);
			end
			read = 1'b0;
		end else if (cmds[idx] == "wait") begin
			// worst case drain time of store and queue
			repeat (IDLE_CYCLES) @(negedge ti_clk);
		end else if (cmds[idx] == "check") begin
			exp_fill  = stream_buffer_pkg::fill_t'(args[idx]);
			check_req = 1'b1;
			@(negedge ti_clk);
			check_req = 1'b0;
		end else begin
			$display("case %0s has an unknown command %0s", names[idx], cmds[idx]);
			setup_errors++;
		end
	endtask

	initial begin
		int i;
		int total;
		write        = 1'b0;
		data_in      = '0;
		read         = 1'b0;
		check_req    = 1'b0;
		exp_fill     = '0;
		case_name    = "reset";
		seed         = 32'h9474_65b7;
		setup_errors = 0;
		n_cases      = 0;
		budget       = RESET_CYCLES;
		load_cases();
		if (n_cases == 0) begin
			$display("no test cases were loaded");
			setup_errors++;
		end
		budget = budget * 2 + 100;
		@(posedge rst_n);
		@(negedge ti_clk);
		for (i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		repeat (2) @(negedge ti_clk);
		total = mismatches + model_errors + setup_errors + uut.u_checker.failures;
		$display("errors: %0d mismatch, %0d model, %0d assertion, %0d setup",
			mismatches, model_errors, uut.u_checker.failures, setup_errors);
		if (total == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (rst_n === 1'b1);
		repeat (budget) @(posedge ti_clk);
		$display("timeout: the run did not finish within %0d cycles", budget);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/stream_buffer_checker.sv
`default_nettype none

module stream_buffer_checker #(
	parameter int STORE_ADDR_W = 4,
	parameter int QUEUE_DEPTH  = 4
) (
	input wire logic                                 ti_clk,
	input wire logic                                 rst_n,
	input wire logic                                 read,
	input wire logic [stream_buffer_pkg::WORD_W-1:0] data_out,
	input wire stream_buffer_pkg::fill_t             fill_count,
	input wire stream_buffer_pkg::stage_t            pk_word,
	input wire logic [STORE_ADDR_W:0]                store_count,
	input wire logic [$clog2(QUEUE_DEPTH + 1)-1:0]   queue_count
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam int MAX_FILL = 2 * ((1 << STORE_ADDR_W) + QUEUE_DEPTH) + 1;

	int failures = 0;

	////////////////////////////////////////////////////////////////////////////
	// buffer properties
	////////////////////////////////////////////////////////////////////////////

	fill_bound: assert property (@(posedge ti_clk) disable iff (!rst_n)
		fill_count <= stream_buffer_pkg::fill_t'(MAX_FILL))
	else begin
		$error("fill count %0d is above the buffer capacity", fill_count);
		failures++;
	end

	// with nothing in store or queue a read cannot move data_out
	empty_read_hold: assert property (@(posedge ti_clk) disable iff (!rst_n)
		(read && queue_count == '0 && store_count == '0) |=> $stable(data_out))
	else begin
		$error("data_out changed after a read on an empty buffer");
		failures++;
	end

	pack_spacing: assert property (@(posedge ti_clk) disable iff (!rst_n)
		pk_word.valid |=> !pk_word.valid)
	else begin
		$error("packer emitted words on two cycles in a row");
		failures++;
	end

endmodule

bind stream_buffer stream_buffer_checker #(
	.STORE_ADDR_W(STORE_ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)
) u_checker (
	.ti_clk(ti_clk), .rst_n(rst_n), .read(read), .data_out(data_out),
	.fill_count(fill_count), .pk_word(pk_word), .store_count(store_count),
	.queue_count(queue_count)
);

`default_nettype wire

// File: verification/stream_buffer_scoreboard.sv
`default_nettype none

module stream_buffer_scoreboard #(
	parameter int STORE_ADDR_W = 4,
	parameter int QUEUE_DEPTH  = 4
) (
	input  wire logic                                 ti_clk,
	input  wire logic                                 rst_n,
	input  wire logic                                 write,
	input  wire stream_buffer_pkg::sample_t           data_in,
	input  wire logic                                 read,
	input  wire logic [stream_buffer_pkg::WORD_W-1:0] data_out,
	input  wire stream_buffer_pkg::fill_t             fill_count,
	input  wire logic                                 check_req,
	input  wire stream_buffer_pkg::fill_t             exp_fill,
	input  wire logic [8*16-1:0]                      case_name,
	output int                                        mismatches,
	output int                                        model_errors
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CAP_WORDS = (1 << STORE_ADDR_W) + QUEUE_DEPTH;

	logic [stream_buffer_pkg::WORD_W-1:0] words [$];
	logic [stream_buffer_pkg::WORD_W-1:0] last_word;
	logic [stream_buffer_pkg::WORD_W-1:0] expected;
	stream_buffer_pkg::sample_t           half;
	logic                                 has_half;
	stream_buffer_pkg::fill_t             model_fill;

	always @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			words.delete();
			last_word    = '0;
			half         = '0;
			has_half     = 1'b0;
			mismatches   = 0;
			model_errors = 0;
		end else begin
			if (read) begin
				// head of the buffer or a repeat of the last word once drained
				if (words.size() > 0) begin
					expected  = words[0];
					last_word = words.pop_front();
				end else begin
					expected = last_word;
				end
				if (data_out !== expected) begin
					$display("MISMATCH case %0s data_out expected %h actual %h",
						case_name, expected, data_out);
					mismatches++;
				end
			end
			if (write) begin
				if (has_half) begin
					words.push_back({half, data_in});
					// the queue keeps its words and the oldest one in the store goes
					if (words.size() > CAP_WORDS) begin
						words.delete(QUEUE_DEPTH);
					end
				end else begin
					half = data_in;
				end
				has_half = ~has_half;
			end
			if (check_req) begin
				model_fill = stream_buffer_pkg::fill_t'(has_half)
					+ stream_buffer_pkg::fill_t'(2 * words.size());
				if (fill_count !== exp_fill) begin
					$display("MISMATCH case %0s fill_count expected %0d actual %0d",
						case_name, exp_fill, fill_count);
					mismatches++;
				end
				if (model_fill != exp_fill) begin
					$display("case %0s: model holds %0d samples, case file expects %0d",
						case_name, model_fill, exp_fill);
					model_errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic ti_clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ns;

	initial begin
		ti_clk = 1'b0;
		forever #(PERIOD_NS / 2) ti_clk = ~ti_clk;
	end

	// release on a falling edge away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge ti_clk);
		@(negedge ti_clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/stream_buffer.sv
`default_nettype none

module stream_buffer #(
	parameter int STORE_ADDR_W = 4,
	parameter int QUEUE_DEPTH  = 4
) (
	input  wire logic                            ti_clk,
	input  wire logic                            rst_n,
	input  wire logic                            write,
	input  wire stream_buffer_pkg::sample_t      data_in,
	input  wire logic                            read,
	output logic [stream_buffer_pkg::WORD_W-1:0] data_out,
	output stream_buffer_pkg::fill_t             fill_count
);

	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	stream_buffer_pkg::stage_t pk_word;
	stream_buffer_pkg::stage_t st_word;
	logic                      pending;
	logic                      st_ready;
	logic [STORE_ADDR_W:0]     store_count;
	logic [QCNT_W-1:0]         queue_count;

	////////////////////////////////////////////////////////////////////////////
	// pack, store, queue
	////////////////////////////////////////////////////////////////////////////

	word_packer u_packer (
		.ti_clk(ti_clk), .rst_n(rst_n), .write(write), .data_in(data_in),
		.pk_word(pk_word), .pending(pending)
	);

	bulk_store #(.STORE_ADDR_W(STORE_ADDR_W)) u_store (
		.ti_clk(ti_clk), .rst_n(rst_n), .pk_word(pk_word),
		.st_word(st_word), .st_ready(st_ready), .store_count(store_count)
	);

	out_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.ti_clk(ti_clk), .rst_n(rst_n), .st_word(st_word), .st_ready(st_ready),
		.read(read), .data_out(data_out), .queue_count(queue_count)
	);

	// capacity seen by the host
	fill_monitor #(.STORE_ADDR_W(STORE_ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) u_fill (
		.ti_clk(ti_clk), .rst_n(rst_n), .pending(pending),
		.store_count(store_count), .queue_count(queue_count), .fill_count(fill_count)
	);

endmodule

`default_nettype wire

// File: verilog/fill_monitor.sv
`default_nettype none

module fill_monitor #(
	parameter int STORE_ADDR_W = 4,
	parameter int QUEUE_DEPTH  = 4
) (
	input  wire logic                          ti_clk,
	input  wire logic                          rst_n,
	input  wire logic                          pending,
	input  wire logic [STORE_ADDR_W:0]         store_count,
	input  wire logic [$clog2(QUEUE_DEPTH + 1)-1:0] queue_count,
	output stream_buffer_pkg::fill_t           fill_count
);

	stream_buffer_pkg::fill_t pending_w;
	stream_buffer_pkg::fill_t store_w;
	stream_buffer_pkg::fill_t queue_w;
	stream_buffer_pkg::fill_t fill_next;

	// packed words hold two samples each
	assign pending_w = stream_buffer_pkg::fill_t'(pending);
	assign store_w   = stream_buffer_pkg::fill_t'(store_count) << 1;
	assign queue_w   = stream_buffer_pkg::fill_t'(queue_count) << 1;
	assign fill_next = pending_w + store_w + queue_w;

	// one cycle behind the stage counts
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			fill_count <= '0;
		end else begin
			fill_count <= fill_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/out_queue.sv
`default_nettype none

module out_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic                              ti_clk,
	input  wire logic                              rst_n,
	input  wire stream_buffer_pkg::stage_t         st_word,
	output logic                                   st_ready,
	input  wire logic                              read,
	output logic [stream_buffer_pkg::WORD_W-1:0]   data_out,
	output logic [$clog2(QUEUE_DEPTH + 1)-1:0]     queue_count
);

	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	logic [stream_buffer_pkg::WORD_W-1:0] q_mem [QUEUE_DEPTH];
	logic [stream_buffer_pkg::WORD_W-1:0] last_q;
	logic [PTR_W-1:0]                     wr_ptr;
	logic [PTR_W-1:0]                     rd_ptr;
	logic                                 empty;
	logic                                 push;
	logic                                 pop;

	// wrap at depth since depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty    = (queue_count == '0);
	assign st_ready = (queue_count != CNT_W'(QUEUE_DEPTH));
	assign push     = st_word.valid & st_ready;
	// a read on an empty queue does nothing
	assign pop      = read & ~empty;

	always_ff @(posedge ti_clk) begin
		if (push) begin
			q_mem[wr_ptr] <= st_word.data.word;
		end
	end

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			queue_count <= '0;
			last_q      <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
				last_q <= q_mem[rd_ptr];
			end
			if (push && !pop) begin
				queue_count <= queue_count + 1'b1;
			end else if (pop && !push) begin
				queue_count <= queue_count - 1'b1;
			end
		end
	end

	// head word or the last one consumed once the queue runs dry
	assign data_out = empty ? last_q : q_mem[rd_ptr];

endmodule

`default_nettype wire

// File: verilog/bulk_store.sv
`default_nettype none

module bulk_store #(
	parameter int STORE_ADDR_W = 4
) (
	input  wire logic                      ti_clk,
	input  wire logic                      rst_n,
	input  wire stream_buffer_pkg::stage_t pk_word,
	output stream_buffer_pkg::stage_t      st_word,
	input  wire logic                      st_ready,
	output logic [STORE_ADDR_W:0]          store_count
);

	localparam int DEPTH = 1 << STORE_ADDR_W;

	stream_buffer_pkg::mem_word_u mem [DEPTH];
	logic [STORE_ADDR_W-1:0]      wr_ptr;
	logic [STORE_ADDR_W-1:0]      rd_ptr;
	logic                         full;
	logic                         push;
	logic                         pop;
	logic                         drop;

	////////////////////////////////////////////////////////////////////////////
	// handshake decode
	////////////////////////////////////////////////////////////////////////////

	assign full = (store_count == (STORE_ADDR_W + 1)'(DEPTH));
	assign push = pk_word.valid;
	assign pop  = st_word.valid & st_ready;

	// oldest word goes when a full store sees no drain this cycle
	assign drop = push & full & ~pop;

	////////////////////////////////////////////////////////////////////////////
	// circular memory
	////////////////////////////////////////////////////////////////////////////

	// words arrive as packed halves
	always_ff @(posedge ti_clk) begin
		if (push) begin
			mem[wr_ptr].halves.hi <= pk_word.data.halves.hi;
			mem[wr_ptr].halves.lo <= pk_word.data.halves.lo;
		end
	end

	// head is offered straight from the array and read back as one word
	assign st_word.valid     = (store_count != '0);
	assign st_word.data.word = mem[rd_ptr].word;

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// read side moves on a drain and also on a drop
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (pop || drop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			store_count <= '0;
		end else begin
			case ({push, pop})
				2'b10: begin
					// count saturates at depth when dropping
					if (!full) begin
						store_count <= store_count + 1'b1;
					end
				end
				2'b01: begin
					store_count <= store_count - 1'b1;
				end
				default: begin
					store_count <= store_count;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/word_packer.sv
`default_nettype none

module word_packer (
	input  wire logic                       ti_clk,
	input  wire logic                       rst_n,
	input  wire logic                       write,
	input  wire stream_buffer_pkg::sample_t data_in,
	output stream_buffer_pkg::stage_t       pk_word,
	output logic                            pending
);

	stream_buffer_pkg::sample_t   hold_q;
	stream_buffer_pkg::mem_word_u pk_data;
	logic                         pk_valid;

	// control path
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			pending  <= 1'b0;
			pk_valid <= 1'b0;
		end else begin
			pk_valid <= write & pending;
			if (write) begin
				pending <= ~pending;
			end
		end
	end

	// first sample waits in hold_q for its partner
	always_ff @(posedge ti_clk) begin
		if (write && !pending) begin
			hold_q <= data_in;
		end
		if (write && pending) begin
			pk_data.halves.hi <= hold_q;
			pk_data.halves.lo <= data_in;
		end
	end

	assign pk_word.valid = pk_valid;
	assign pk_word.data  = pk_data;

endmodule

`default_nettype wire

// File: verilog/stream_buffer_pkg.sv
`default_nettype none

package stream_buffer_pkg;

	localparam int SAMPLE_W = 16;
	localparam int WORD_W   = 2 * SAMPLE_W;
	localparam int FILL_W   = 32;

	// one input sample from the acquisition side
	typedef logic [SAMPLE_W-1:0] sample_t;

	// first sample of a pair lands in the upper half
	typedef struct packed {
		sample_t hi;
		sample_t lo;
	} half_pair_t;

	// store word that is filled as two halves and drained as one word
	typedef union packed {
		logic [WORD_W-1:0] word;
		half_pair_t        halves;
	} mem_word_u;

	typedef struct packed {
		logic      valid;
		mem_word_u data;
	} stage_t;

	// number of 16-bit samples held across the whole buffer
	typedef logic [FILL_W-1:0] fill_t;

endpackage

`default_nettype wire
